//--- logic/core_sizes_pkg.sv
package core_sizes_pkg;

    // Address space
    localparam int size_addr   = 16;  // Pc and data address
    localparam int size_data   = 32;  // Instruction, result, memory word

    // Operation fields
    localparam int size_opc    = 4;
    localparam int size_tgt_gp = 4;   // 16 general-purpose registers
    localparam int size_tgt_sr = 2;   // 4 special registers

    localparam int num_gp_regs = 1 << size_tgt_gp;
    localparam int num_sr_regs = 1 << size_tgt_sr;

    typedef logic [size_addr-1:0]   addr_t;
    typedef logic [size_data-1:0]   data_t;
    typedef logic [size_opc-1:0]    opc_t_raw;
    typedef logic [size_tgt_gp-1:0] tgt_gp_t;
    typedef logic [size_tgt_sr-1:0] tgt_sr_t;

endpackage

//--- logic/core_ops_pkg.sv
package core_ops_pkg;

    typedef enum logic [core_sizes_pkg::size_opc-1:0] {
        op_nop   = 0,
        op_alu   = 1,
        op_load  = 2,
        op_store = 3
    } opc_e;

    // Unknown codes fall back to ALU pass-through
    function automatic opc_e decode(input core_sizes_pkg::opc_t_raw opc);
        case (opc)
            op_nop:   return op_nop;
            op_load:  return op_load;
            op_store: return op_store;
            default:  return op_alu;
        endcase
    endfunction

    function automatic logic is_load(input core_sizes_pkg::opc_t_raw opc);
        return decode(opc) == op_load;
    endfunction

    function automatic logic is_store(input core_sizes_pkg::opc_t_raw opc);
        return decode(opc) == op_store;
    endfunction

    function automatic logic is_mem(input core_sizes_pkg::opc_t_raw opc);
        return is_load(opc) || is_store(opc);
    endfunction

endpackage

//--- logic/stage_if.sv
`timescale 1ns/1ps

interface stage_if;

    logic                      valid;  // One cycle per operation
    core_sizes_pkg::addr_t     pc;
    core_sizes_pkg::data_t     instr;
    core_sizes_pkg::opc_t_raw  opc;
    core_sizes_pkg::tgt_gp_t   tgt_gp;
    logic                      tgt_gp_we;
    core_sizes_pkg::tgt_sr_t   tgt_sr;
    logic                      tgt_sr_we;
    core_sizes_pkg::data_t     result;

    modport src (
        output valid, pc, instr, opc,
        output tgt_gp, tgt_gp_we,
        output tgt_sr, tgt_sr_we,
        output result
    );

    // No back-pressure toward the source
    modport snk (
        input valid, pc, instr, opc,
        input tgt_gp, tgt_gp_we,
        input tgt_sr, tgt_sr_we,
        input result
    );

endinterface

//--- logic/mem_access_stage.sv
`timescale 1ns/1ps

module mem_access_stage (
    input  logic                      iw_clk,
    input  logic                      iw_rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  core_sizes_pkg::addr_t     in_pc,
    input  core_sizes_pkg::data_t     in_instr,
    input  core_sizes_pkg::opc_t_raw  in_opc,
    input  core_sizes_pkg::tgt_gp_t   in_tgt_gp,
    input  logic                      in_tgt_gp_we,
    input  core_sizes_pkg::tgt_sr_t   in_tgt_sr,
    input  logic                      in_tgt_sr_we,
    input  core_sizes_pkg::data_t     in_result,
    input  core_sizes_pkg::data_t     in_st_data,
    output logic                      mem_req,
    output logic                      mem_we,
    output core_sizes_pkg::addr_t     mem_addr,
    output core_sizes_pkg::data_t     mem_wdata,
    input  logic                      mem_ack,
    input  core_sizes_pkg::data_t     mem_rdata,
    stage_if.src                      ma_out
);
    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release
    } ma_state_e;

    ma_state_e                 state_q;
    logic                      lat_valid;
    core_sizes_pkg::addr_t     lat_pc;
    core_sizes_pkg::data_t     lat_instr;
    core_sizes_pkg::opc_t_raw  lat_opc;
    core_sizes_pkg::tgt_gp_t   lat_tgt_gp;
    logic                      lat_tgt_gp_we;
    core_sizes_pkg::tgt_sr_t   lat_tgt_sr;
    logic                      lat_tgt_sr_we;
    core_sizes_pkg::data_t     lat_result;
    core_sizes_pkg::data_t     lat_st_data;
    logic                      lat_is_mem;
    logic                      accept;
    logic                      out_load;
    logic                      load_done;

    assign lat_is_mem = lat_valid && core_ops_pkg::is_mem(lat_opc);
    assign in_ready   = (state_q == st_idle) && !lat_is_mem;  // Stall during access
    assign accept     = in_valid && in_ready;
    assign load_done  = (state_q == st_request) && mem_ack && core_ops_pkg::is_load(lat_opc);

    // ALU ops leave at once, memory ops once ack has dropped
    assign out_load = ((state_q == st_idle) && lat_valid && !lat_is_mem)
                    || ((state_q == st_release) && !mem_ack);

    assign mem_req   = (state_q == st_request);
    assign mem_we    = core_ops_pkg::is_store(lat_opc);
    assign mem_addr  = lat_result[core_sizes_pkg::size_addr-1:0];  // Address from result field
    assign mem_wdata = lat_st_data;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state_q      <= st_idle;
            lat_valid    <= 1'b0;
            ma_out.valid <= 1'b0;
        end else begin
            ma_out.valid <= out_load;
            if (accept) begin
                lat_valid <= 1'b1;
            end else if (out_load) begin
                lat_valid <= 1'b0;
            end
            case (state_q)
                st_idle: begin
                    if (lat_is_mem) begin
                        state_q <= st_request;
                    end
                end
                st_request: begin
                    if (mem_ack) begin
                        state_q <= st_release;  // Drops req
                    end
                end
                st_release: begin
                    if (!mem_ack) begin
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge iw_clk) begin
        if (accept) begin
            lat_pc        <= in_pc;
            lat_instr     <= in_instr;
            lat_opc       <= in_opc;
            lat_tgt_gp    <= in_tgt_gp;
            lat_tgt_gp_we <= in_tgt_gp_we;
            lat_tgt_sr    <= in_tgt_sr;
            lat_tgt_sr_we <= in_tgt_sr_we;
            lat_result    <= in_result;
            lat_st_data   <= in_st_data;
        end else if (load_done) begin
            lat_result    <= mem_rdata;  // Load value replaces result
        end
        if (out_load) begin
            ma_out.pc        <= lat_pc;
            ma_out.instr     <= lat_instr;
            ma_out.opc       <= lat_opc;
            ma_out.tgt_gp    <= lat_tgt_gp;
            ma_out.tgt_gp_we <= lat_tgt_gp_we;
            ma_out.tgt_sr    <= lat_tgt_sr;
            ma_out.tgt_sr_we <= lat_tgt_sr_we;
            ma_out.result    <= lat_result;
        end
    end

endmodule

//--- logic/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_WORDS = 256,
    parameter int MEM_WAIT  = 2
) (
    input  logic                   iw_clk,
    input  logic                   iw_rst,
    input  logic                   mem_req,
    input  logic                   mem_we,
    input  core_sizes_pkg::addr_t  mem_addr,
    input  core_sizes_pkg::data_t  mem_wdata,
    output logic                   mem_ack,
    output core_sizes_pkg::data_t  mem_rdata
);
    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = (MEM_WAIT > 0) ? $clog2(MEM_WAIT + 1) : 1;

    core_sizes_pkg::data_t  mem_q [MEM_WORDS];
    logic [CNT_W-1:0]       wait_cnt;
    logic [IDX_W-1:0]       idx;
    logic                   ack_rise;

    assign idx      = mem_addr[IDX_W-1:0];  // Low word bits only
    assign ack_rise = mem_req && !mem_ack && (wait_cnt == CNT_W'(MEM_WAIT));

    // Wait counter and ack phase
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wait_cnt <= '0;
            mem_ack  <= 1'b0;
        end else if (ack_rise) begin
            wait_cnt <= '0;
            mem_ack  <= 1'b1;
        end else if (mem_req && !mem_ack) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else if (!mem_req) begin
            mem_ack  <= 1'b0;  // Release after req falls
        end
    end

    // Access happens on the ack edge, rdata held while ack is high
    always_ff @(posedge iw_clk) begin
        if (ack_rise) begin
            if (mem_we) begin
                mem_q[idx] <= mem_wdata;
            end else begin
                mem_rdata <= mem_q[idx];
            end
        end
    end

endmodule

//--- logic/write_back_stage.sv
`timescale 1ns/1ps

module write_back_stage (
    input  logic                     iw_clk,
    input  logic                     iw_rst,
    stage_if.snk                     wb_in,
    input  core_sizes_pkg::tgt_gp_t  gp_rd_addr,
    output core_sizes_pkg::data_t    gp_rd_data,
    input  core_sizes_pkg::tgt_sr_t  sr_rd_addr,
    output core_sizes_pkg::data_t    sr_rd_data,
    output logic                     retire_valid,
    output core_sizes_pkg::addr_t    retire_pc
);
    core_sizes_pkg::data_t  gp_rf [core_sizes_pkg::num_gp_regs];
    core_sizes_pkg::data_t  sr_rf [core_sizes_pkg::num_sr_regs];
    logic                   gp_wr;
    logic                   sr_wr;

    assign gp_wr = wb_in.valid && wb_in.tgt_gp_we;
    assign sr_wr = wb_in.valid && wb_in.tgt_sr_we;

    // Decode-side read ports
    assign gp_rd_data = gp_rf[gp_rd_addr];
    assign sr_rd_data = sr_rf[sr_rd_addr];

    // Files commit on the same edge the retire latch loads
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < core_sizes_pkg::num_gp_regs; i++) begin
                gp_rf[i] <= '0;
            end
        end else if (gp_wr) begin
            gp_rf[wb_in.tgt_gp] <= wb_in.result;
        end
    end

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < core_sizes_pkg::num_sr_regs; i++) begin
                sr_rf[i] <= '0;
            end
        end else if (sr_wr) begin
            sr_rf[wb_in.tgt_sr] <= wb_in.result;
        end
    end

    // Retire latch
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_in.valid;  // One pulse per operation
        end
    end

    always_ff @(posedge iw_clk) begin
        if (wb_in.valid) begin
            retire_pc <= wb_in.pc;
        end
    end

endmodule

//--- logic/pipe_tail_top.sv
`timescale 1ns/1ps

module pipe_tail_top #(
    parameter int MEM_WORDS = 256,
    parameter int MEM_WAIT  = 2
) (
    input  logic                      iw_clk,
    input  logic                      iw_rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  core_sizes_pkg::addr_t     in_pc,
    input  core_sizes_pkg::data_t     in_instr,
    input  core_sizes_pkg::opc_t_raw  in_opc,
    input  core_sizes_pkg::tgt_gp_t   in_tgt_gp,
    input  logic                      in_tgt_gp_we,
    input  core_sizes_pkg::tgt_sr_t   in_tgt_sr,
    input  logic                      in_tgt_sr_we,
    input  core_sizes_pkg::data_t     in_result,
    input  core_sizes_pkg::data_t     in_st_data,
    input  core_sizes_pkg::tgt_gp_t   gp_rd_addr,
    output core_sizes_pkg::data_t     gp_rd_data,
    input  core_sizes_pkg::tgt_sr_t   sr_rd_addr,
    output core_sizes_pkg::data_t     sr_rd_data,
    output logic                      retire_valid,
    output core_sizes_pkg::addr_t     retire_pc
);
    logic                   mem_req;
    logic                   mem_we;
    core_sizes_pkg::addr_t  mem_addr;
    core_sizes_pkg::data_t  mem_wdata;
    logic                   mem_ack;
    core_sizes_pkg::data_t  mem_rdata;

    stage_if ma_to_wb ();

    mem_access_stage mem_access_stage_i (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_instr     (in_instr),
        .in_opc       (in_opc),
        .in_tgt_gp    (in_tgt_gp),
        .in_tgt_gp_we (in_tgt_gp_we),
        .in_tgt_sr    (in_tgt_sr),
        .in_tgt_sr_we (in_tgt_sr_we),
        .in_result    (in_result),
        .in_st_data   (in_st_data),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .ma_out       (ma_to_wb.src)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS),
        .MEM_WAIT  (MEM_WAIT)
    ) data_mem_i (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    write_back_stage write_back_stage_i (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .wb_in        (ma_to_wb.snk),
        .gp_rd_addr   (gp_rd_addr),
        .gp_rd_data   (gp_rd_data),
        .sr_rd_addr   (sr_rd_addr),
        .sr_rd_data   (sr_rd_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc)
    );

endmodule

//--- test/tb_pipe_tail.sv
`timescale 1ns/1ps

module tb_pipe_tail;

    localparam int MEM_WORDS   = 256;
    localparam int MEM_WAIT    = 2;
    localparam int NUM_OPS     = 39;                     // All tests together
    localparam int WORST_LAT   = 2 * MEM_WAIT + 10;      // Memory op, accept to retire
    localparam int CYCLE_LIMIT = 10 + NUM_OPS * WORST_LAT + 200;

    logic                      iw_clk;
    logic                      iw_rst;
    logic                      in_valid;
    logic                      in_ready;
    core_sizes_pkg::addr_t     in_pc;
    core_sizes_pkg::data_t     in_instr;
    core_sizes_pkg::opc_t_raw  in_opc;
    core_sizes_pkg::tgt_gp_t   in_tgt_gp;
    logic                      in_tgt_gp_we;
    core_sizes_pkg::tgt_sr_t   in_tgt_sr;
    logic                      in_tgt_sr_we;
    core_sizes_pkg::data_t     in_result;
    core_sizes_pkg::data_t     in_st_data;
    core_sizes_pkg::tgt_gp_t   gp_rd_addr;
    core_sizes_pkg::data_t     gp_rd_data;
    core_sizes_pkg::tgt_sr_t   sr_rd_addr;
    core_sizes_pkg::data_t     sr_rd_data;
    logic                      retire_valid;
    core_sizes_pkg::addr_t     retire_pc;

    integer                    seed;
    int                        errors;
    int                        checks;
    int                        cycle_cnt = 0;
    core_sizes_pkg::data_t     gp_model [core_sizes_pkg::num_gp_regs];
    core_sizes_pkg::data_t     sr_model [core_sizes_pkg::num_sr_regs];
    core_sizes_pkg::data_t     mem_model [MEM_WORDS];
    core_sizes_pkg::addr_t     issued_pcs [$];
    core_sizes_pkg::addr_t     retired_pcs [$];
    core_sizes_pkg::addr_t     written_addrs [$];   // Safe load addresses

    pipe_tail_top #(
        .MEM_WORDS (MEM_WORDS),
        .MEM_WAIT  (MEM_WAIT)
    ) pipe_tail_top_i (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_pc        (in_pc),
        .in_instr     (in_instr),
        .in_opc       (in_opc),
        .in_tgt_gp    (in_tgt_gp),
        .in_tgt_gp_we (in_tgt_gp_we),
        .in_tgt_sr    (in_tgt_sr),
        .in_tgt_sr_we (in_tgt_sr_we),
        .in_result    (in_result),
        .in_st_data   (in_st_data),
        .gp_rd_addr   (gp_rd_addr),
        .gp_rd_data   (gp_rd_data),
        .sr_rd_addr   (sr_rd_addr),
        .sr_rd_data   (sr_rd_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc)
    );

    always #20 iw_clk = ~iw_clk;

    always @(posedge iw_clk) cycle_cnt <= cycle_cnt + 1;

    // Retire trace, sampled mid-cycle
    always @(negedge iw_clk) begin
        if (!iw_rst && retire_valid) begin
            retired_pcs.push_back(retire_pc);
        end
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("Timeout after %0d cycles, the pipeline stopped retiring", cycle_cnt);
        $display("Regression failed");
        $finish;
    end

    task automatic check_data(input string name, input core_sizes_pkg::data_t got,
                              input core_sizes_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input core_sizes_pkg::addr_t got,
                            input core_sizes_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Expected effect of one retired op
    task automatic apply_model(input core_sizes_pkg::opc_t_raw opc,
                               input core_sizes_pkg::tgt_gp_t tgt_gp, input logic gp_we,
                               input core_sizes_pkg::tgt_sr_t tgt_sr, input logic sr_we,
                               input core_sizes_pkg::data_t result,
                               input core_sizes_pkg::data_t st_data);
        int                     idx;
        core_sizes_pkg::data_t  value;
        idx   = int'(result[15:0]) % MEM_WORDS;  // Memory sees low address bits
        value = result;
        if (opc == core_ops_pkg::op_store) begin
            mem_model[idx] = st_data;
            written_addrs.push_back(result[15:0]);
        end else if (opc == core_ops_pkg::op_load) begin
            value = mem_model[idx];
        end
        if (gp_we) gp_model[tgt_gp] = value;
        if (sr_we) sr_model[tgt_sr] = value;
    endtask

    task automatic send_op(input core_sizes_pkg::addr_t pc, input core_sizes_pkg::opc_t_raw opc,
                           input core_sizes_pkg::tgt_gp_t tgt_gp, input logic gp_we,
                           input core_sizes_pkg::tgt_sr_t tgt_sr, input logic sr_we,
                           input core_sizes_pkg::data_t result,
                           input core_sizes_pkg::data_t st_data);
        in_valid     = 1'b1;
        in_pc        = pc;
        in_instr     = $random(seed);
        in_opc       = opc;
        in_tgt_gp    = tgt_gp;
        in_tgt_gp_we = gp_we;
        in_tgt_sr    = tgt_sr;
        in_tgt_sr_we = sr_we;
        in_result    = result;
        in_st_data   = st_data;
        while (!in_ready) begin
            @(posedge iw_clk);
            #1;
        end
        @(posedge iw_clk);  // Accepting edge
        #1;
        in_valid = 1'b0;
        issued_pcs.push_back(pc);
        apply_model(opc, tgt_gp, gp_we, tgt_sr, sr_we, result, st_data);
    endtask

    task automatic wait_ready();
        while (!in_ready) begin
            @(posedge iw_clk);
            #1;
        end
    endtask

    task automatic wait_drain();
        while (retired_pcs.size() != issued_pcs.size()) begin
            @(posedge iw_clk);
            #1;
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < core_sizes_pkg::num_gp_regs; i++) begin
            gp_rd_addr = core_sizes_pkg::tgt_gp_t'(i);
            #1;
            check_data($sformatf("gp_rd_data[%0d]", i), gp_rd_data, gp_model[i]);
        end
        for (int i = 0; i < core_sizes_pkg::num_sr_regs; i++) begin
            sr_rd_addr = core_sizes_pkg::tgt_sr_t'(i);
            #1;
            check_data($sformatf("sr_rd_data[%0d]", i), sr_rd_data, sr_model[i]);
        end
        @(posedge iw_clk);
        #1;
    endtask

    task automatic test_reset();
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_regs();
    endtask

    task automatic test_alu_writeback();
        core_sizes_pkg::data_t    val;
        core_sizes_pkg::tgt_gp_t  tgt;
        logic [31:0]              rnd;
        val = $random(seed);
        rnd = $random(seed);
        tgt = rnd[3:0];
        send_op(16'h0010, core_ops_pkg::op_alu, tgt, 1'b1, 2'd0, 1'b0, val, '0);
        @(posedge iw_clk);
        #1;
        check_flag("retire_valid", retire_valid, 1'b0);
        @(posedge iw_clk);  // Two edges after acceptance
        #1;
        check_flag("retire_valid", retire_valid, 1'b1);
        check_pc("retire_pc", retire_pc, 16'h0010);
        gp_rd_addr = tgt;
        #1;
        check_data("gp_rd_data", gp_rd_data, val);
        send_op(16'h0014, core_ops_pkg::op_nop, tgt, 1'b0, 2'd1, 1'b0, ~val, '0);
        send_op(16'h0018, core_ops_pkg::op_alu, tgt, 1'b0, 2'd2, 1'b0, val ^ 32'h5a5a_5a5a, '0);
        wait_drain();
        check_regs();
    endtask

    task automatic test_special_regs();
        for (int k = 0; k < core_sizes_pkg::num_sr_regs; k++) begin
            send_op(core_sizes_pkg::addr_t'(16'h0020 + 4 * k), core_ops_pkg::op_alu,
                    core_sizes_pkg::tgt_gp_t'(k), 1'b0, core_sizes_pkg::tgt_sr_t'(k), 1'b1,
                    $random(seed), '0);
        end
        wait_drain();
        check_regs();  // GP file must be untouched
    endtask

    task automatic test_store_load();
        core_sizes_pkg::data_t    word;
        core_sizes_pkg::tgt_gp_t  tgt;
        logic [31:0]              rnd;
        rnd  = $random(seed);
        word = $random(seed);
        tgt  = rnd[19:16];
        send_op(16'h0040, core_ops_pkg::op_store, 4'd0, 1'b0, 2'd0, 1'b0,
                {16'h0000, rnd[15:0]}, word);
        check_flag("in_ready", in_ready, 1'b0);
        wait_ready();
        send_op(16'h0044, core_ops_pkg::op_load, tgt, 1'b1, 2'd0, 1'b0,
                {16'h0000, rnd[15:0]}, '0);
        check_flag("in_ready", in_ready, 1'b0);
        wait_drain();
        gp_rd_addr = tgt;
        #1;
        check_data("gp_rd_data", gp_rd_data, word);
        check_regs();
    endtask

    task automatic test_stream();
        core_sizes_pkg::addr_t     pc;
        core_sizes_pkg::opc_t_raw  opc;
        core_sizes_pkg::data_t     data;
        core_sizes_pkg::data_t     result;
        logic                      gp_we;
        logic                      sr_we;
        logic [31:0]               rnd;
        int                        pick;
        issued_pcs.delete();
        retired_pcs.delete();
        pc = 16'h0100;
        repeat (30) begin
            rnd    = $random(seed);
            data   = $random(seed);
            opc    = core_ops_pkg::op_alu;
            result = data;
            gp_we  = rnd[7];
            sr_we  = rnd[8];
            case (rnd[2:0])
                3'd0, 3'd1: begin
                    if (!rnd[3]) opc = 4'd4 + {1'b0, rnd[6:4]};  // Unknown codes act as ALU
                end
                3'd2: begin
                    opc   = core_ops_pkg::op_nop;
                    gp_we = 1'b0;
                    sr_we = 1'b0;
                end
                3'd3, 3'd4: begin
                    opc    = core_ops_pkg::op_store;
                    result = {16'h0000, rnd[31:16]};
                    gp_we  = 1'b0;
                    sr_we  = 1'b0;
                end
                default: begin
                    if (written_addrs.size() > 0) begin
                        pick   = int'(rnd[31:16]) % written_addrs.size();
                        opc    = core_ops_pkg::op_load;
                        result = {16'h0000, written_addrs[pick]};
                        gp_we  = 1'b1;
                    end
                end
            endcase
            send_op(pc, opc, rnd[12:9], gp_we, rnd[14:13], sr_we, result, data);
            pc = pc + 16'd4;
            if (rnd[31:30] == 2'b00) begin
                @(posedge iw_clk);  // Occasional bubble
                #1;
            end
        end
        wait_drain();
        foreach (issued_pcs[i]) begin
            check_pc($sformatf("retire_pc[%0d]", i), retired_pcs[i], issued_pcs[i]);
        end
        check_regs();
    endtask

    initial begin
        seed         = 32'h1d20;
        errors       = 0;
        checks       = 0;
        iw_clk       = 1'b0;
        iw_rst       = 1'b1;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_instr     = '0;
        in_opc       = '0;
        in_tgt_gp    = '0;
        in_tgt_gp_we = 1'b0;
        in_tgt_sr    = '0;
        in_tgt_sr_we = 1'b0;
        in_result    = '0;
        in_st_data   = '0;
        gp_rd_addr   = '0;
        sr_rd_addr   = '0;
        foreach (gp_model[i]) gp_model[i] = '0;
        foreach (sr_model[i]) sr_model[i] = '0;
        repeat (10) @(posedge iw_clk);
        #1;
        iw_rst = 1'b0;
        test_reset();
        test_alu_writeback();
        test_special_regs();
        test_store_load();
        test_stream();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- src.f
logic/core_sizes_pkg.sv
logic/core_ops_pkg.sv
logic/stage_if.sv
logic/mem_access_stage.sv
logic/data_mem.sv
logic/write_back_stage.sv
logic/pipe_tail_top.sv
test/tb_pipe_tail.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the pipeline tail testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_pipe_tail
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pipe_tail)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
